/* Bender.yml */
package:
  name: mem_subsystem

sources:
  - common/mem_bus_pkg.sv
  - common/sdram_pkg.sv
  - design/cache_req_port.sv
  - arbiter/sdram_arbiter.sv
  - sdram_ctrl/sdram_ctrl.sv
  - design/mem_subsystem_top.sv
  - target: test
    files:
      - verification/mem_subsystem_checker.sv
      - verification/mem_subsystem_tb.sv

/* arbiter/sdram_arbiter.sv */
module sdram_arbiter
    import mem_bus_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,

    // Instruction side port
    input  logic              i_pend,
    input  logic [ADDR_W-1:0] i_addr,
    input  mem_op_e           i_op,
    input  logic [BE_W-1:0]   i_be,
    input  logic [DATA_W-1:0] i_wdata,
    output logic              i_take,
    output logic              i_rvalid,

    // Data side port
    input  logic              d_pend,
    input  logic [ADDR_W-1:0] d_addr,
    input  mem_op_e           d_op,
    input  logic [BE_W-1:0]   d_be,
    input  logic [DATA_W-1:0] d_wdata,
    output logic              d_take,
    output logic              d_rvalid,

    // Controller command side
    output logic              rd_n,
    output logic              wr_n,
    output logic [ADDR_W-1:0] addr,
    output logic [BE_W-1:0]   dqm,
    output logic [DATA_W-1:0] wdata,
    input  logic              busy_n,
    input  logic              rd_valid
);

    arb_state_e        state;
    arb_state_e        state_nxt;
    logic              grant;
    logic              own_i;

    // Winner of this cycle, instruction side first
    mem_op_e           sel_op;
    logic [ADDR_W-1:0] sel_addr;
    logic [BE_W-1:0]   sel_be;
    logic [DATA_W-1:0] sel_wdata;

    // Command held while the controller works on it
    mem_op_e           lat_op;
    logic [ADDR_W-1:0] lat_addr;
    logic [BE_W-1:0]   lat_be;
    logic [DATA_W-1:0] lat_wdata;

    assign grant  = (state == ARB_IDLE) && busy_n && (i_pend || d_pend);
    assign i_take = grant && i_pend;
    assign d_take = grant && !i_pend;

    assign sel_op    = i_pend ? i_op    : d_op;
    assign sel_addr  = i_pend ? i_addr  : d_addr;
    assign sel_be    = i_pend ? i_be    : d_be;
    assign sel_wdata = i_pend ? i_wdata : d_wdata;

    always_comb begin
        state_nxt = state;
        case (state)
            ARB_IDLE: begin
                if (grant) begin
                    state_nxt = ARB_BUSY;
                end
            end
            ARB_BUSY: begin
                // Writes finish once sampled, reads on the returned data
                if ((lat_op == MEM_WRITE) || rd_valid) begin
                    state_nxt = ARB_IDLE;
                end
            end
            default: state_nxt = ARB_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ARB_IDLE;
            own_i <= 1'b0;
        end else begin
            state <= state_nxt;
            if (grant) begin
                own_i <= i_pend;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            lat_op    <= sel_op;
            lat_addr  <= sel_addr;
            lat_be    <= sel_be;
            lat_wdata <= sel_wdata;
        end
    end

    // Strobes only in the take cycle, the controller samples them there
    always_comb begin
        rd_n  = 1'b1;
        wr_n  = 1'b1;
        addr  = '0;
        dqm   = '1;
        wdata = '0;
        if (grant) begin
            rd_n  = (sel_op != MEM_READ);
            wr_n  = (sel_op != MEM_WRITE);
            addr  = sel_addr;
            dqm   = ~sel_be;
            wdata = sel_wdata;
        end else if (state == ARB_BUSY) begin
            addr  = lat_addr;
            dqm   = ~lat_be;
            wdata = lat_wdata;
        end
    end

    // Read completion goes back to the side recorded at take
    assign i_rvalid = (state == ARB_BUSY) && own_i && rd_valid;
    assign d_rvalid = (state == ARB_BUSY) && !own_i && rd_valid;

endmodule

/* common/mem_bus_pkg.sv */
package mem_bus_pkg;

    // Client side bus geometry
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int BYTE_W = 8;
    localparam int BE_W   = DATA_W / BYTE_W;

    // Request opcode carried from a client through its port to the arbiter
    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

    // Arbiter FSM
    // IDLE may hand out a take, BUSY waits for the command to finish
    typedef enum logic {
        ARB_IDLE = 1'b0,
        ARB_BUSY = 1'b1
    } arb_state_e;

endpackage

/* common/sdram_pkg.sv */
package sdram_pkg;

    // Cycles from the accepting edge to rd_valid
    localparam int CAS_LATENCY  = 3;

    // Cycles that busy_n stays low after a write
    localparam int WRITE_CYCLES = 2;

    // Word storage, indexed by byte address bits 9:2
    localparam int MEM_WORDS = 256;
    localparam int IDX_W     = $clog2(MEM_WORDS);
    localparam int WORD_LSB  = 2;

    // Counter wide enough for the longer of the two delays
    localparam int CNT_W = $clog2((CAS_LATENCY > WRITE_CYCLES) ? CAS_LATENCY : WRITE_CYCLES);

    // Controller FSM
    typedef enum logic [1:0] {
        CTRL_IDLE  = 2'd0,
        CTRL_READ  = 2'd1,
        CTRL_WRITE = 2'd2
    } ctrl_state_e;

endpackage

/* design/cache_req_port.sv */
module cache_req_port
    import mem_bus_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,

    // Client side
    input  logic              req,
    input  logic [ADDR_W-1:0] addr,
    input  mem_op_e           op,
    input  logic [BE_W-1:0]   be,
    input  logic [DATA_W-1:0] wdata,
    output logic              gnt,
    output logic              rvalid,
    output logic [DATA_W-1:0] rdata,

    // Arbiter side
    output logic              pend,
    output logic [ADDR_W-1:0] p_addr,
    output mem_op_e           p_op,
    output logic [BE_W-1:0]   p_be,
    output logic [DATA_W-1:0] p_wdata,
    input  logic              take,
    input  logic              arb_rvalid,
    input  logic [DATA_W-1:0] arb_rdata
);

    logic full;
    logic rd_wait;

    // Only an empty buffer can accept a new request
    assign gnt  = req && !full;
    assign pend = full;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (gnt) begin
            full <= 1'b1;
        end else if (take) begin
            full <= 1'b0;
        end
    end

    // Request payload, captured on the grant edge
    always_ff @(posedge clk) begin
        if (gnt) begin
            p_addr  <= addr;
            p_op    <= op;
            p_be    <= be;
            p_wdata <= wdata;
        end
    end

    // A taken read waits here until the arbiter returns its data
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_wait <= 1'b0;
        end else if (take && (p_op == MEM_READ)) begin
            rd_wait <= 1'b1;
        end else if (arb_rvalid) begin
            rd_wait <= 1'b0;
        end
    end

    assign rvalid = rd_wait && arb_rvalid;
    assign rdata  = arb_rdata;

endmodule

/* design/mem_subsystem_top.sv */
module mem_subsystem_top
    import mem_bus_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,

    // Instruction side client
    input  logic              i_req,
    input  logic [ADDR_W-1:0] i_addr,
    input  mem_op_e           i_op,
    input  logic [BE_W-1:0]   i_be,
    input  logic [DATA_W-1:0] i_wdata,
    output logic              i_gnt,
    output logic              i_rvalid,
    output logic [DATA_W-1:0] i_rdata,

    // Data side client
    input  logic              d_req,
    input  logic [ADDR_W-1:0] d_addr,
    input  mem_op_e           d_op,
    input  logic [BE_W-1:0]   d_be,
    input  logic [DATA_W-1:0] d_wdata,
    output logic              d_gnt,
    output logic              d_rvalid,
    output logic [DATA_W-1:0] d_rdata
);

    // Port to arbiter
    logic              i_pend;
    logic [ADDR_W-1:0] i_p_addr;
    mem_op_e           i_p_op;
    logic [BE_W-1:0]   i_p_be;
    logic [DATA_W-1:0] i_p_wdata;
    logic              i_take;
    logic              i_arb_rvalid;

    logic              d_pend;
    logic [ADDR_W-1:0] d_p_addr;
    mem_op_e           d_p_op;
    logic [BE_W-1:0]   d_p_be;
    logic [DATA_W-1:0] d_p_wdata;
    logic              d_take;
    logic              d_arb_rvalid;

    // Arbiter to controller
    logic              rd_n;
    logic              wr_n;
    logic [ADDR_W-1:0] sd_addr;
    logic [BE_W-1:0]   dqm;
    logic [DATA_W-1:0] sd_wdata;
    logic              busy_n;
    logic              rd_valid;
    logic [DATA_W-1:0] sd_rdata;

    cache_req_port i_port (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (i_req),
        .addr       (i_addr),
        .op         (i_op),
        .be         (i_be),
        .wdata      (i_wdata),
        .gnt        (i_gnt),
        .rvalid     (i_rvalid),
        .rdata      (i_rdata),
        .pend       (i_pend),
        .p_addr     (i_p_addr),
        .p_op       (i_p_op),
        .p_be       (i_p_be),
        .p_wdata    (i_p_wdata),
        .take       (i_take),
        .arb_rvalid (i_arb_rvalid),
        .arb_rdata  (sd_rdata)
    );

    cache_req_port d_port (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (d_req),
        .addr       (d_addr),
        .op         (d_op),
        .be         (d_be),
        .wdata      (d_wdata),
        .gnt        (d_gnt),
        .rvalid     (d_rvalid),
        .rdata      (d_rdata),
        .pend       (d_pend),
        .p_addr     (d_p_addr),
        .p_op       (d_p_op),
        .p_be       (d_p_be),
        .p_wdata    (d_p_wdata),
        .take       (d_take),
        .arb_rvalid (d_arb_rvalid),
        .arb_rdata  (sd_rdata)
    );

    sdram_arbiter sdram_arbiter_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_pend   (i_pend),
        .i_addr   (i_p_addr),
        .i_op     (i_p_op),
        .i_be     (i_p_be),
        .i_wdata  (i_p_wdata),
        .i_take   (i_take),
        .i_rvalid (i_arb_rvalid),
        .d_pend   (d_pend),
        .d_addr   (d_p_addr),
        .d_op     (d_p_op),
        .d_be     (d_p_be),
        .d_wdata  (d_p_wdata),
        .d_take   (d_take),
        .d_rvalid (d_arb_rvalid),
        .rd_n     (rd_n),
        .wr_n     (wr_n),
        .addr     (sd_addr),
        .dqm      (dqm),
        .wdata    (sd_wdata),
        .busy_n   (busy_n),
        .rd_valid (rd_valid)
    );

    sdram_ctrl sdram_ctrl_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_n     (rd_n),
        .wr_n     (wr_n),
        .addr     (sd_addr),
        .dqm      (dqm),
        .wdata    (sd_wdata),
        .busy_n   (busy_n),
        .rd_valid (rd_valid),
        .rdata    (sd_rdata)
    );

endmodule

/* list.f */
common/mem_bus_pkg.sv
common/sdram_pkg.sv
design/cache_req_port.sv
arbiter/sdram_arbiter.sv
sdram_ctrl/sdram_ctrl.sv
design/mem_subsystem_top.sv
verification/mem_subsystem_checker.sv
verification/mem_subsystem_tb.sv

/* sdram_ctrl/sdram_ctrl.sv */
module sdram_ctrl
    import mem_bus_pkg::*;
    import sdram_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,

    // Command inputs, strobes active low
    input  logic              rd_n,
    input  logic              wr_n,
    input  logic [ADDR_W-1:0] addr,
    input  logic [BE_W-1:0]   dqm,
    input  logic [DATA_W-1:0] wdata,

    // Status and read return
    output logic              busy_n,
    output logic              rd_valid,
    output logic [DATA_W-1:0] rdata
);

    ctrl_state_e       state;
    logic [CNT_W-1:0]  cnt;
    logic [IDX_W-1:0]  idx;
    logic              accept_wr;
    logic              accept_rd;
    logic [DATA_W-1:0] rdata_q;

    logic [DATA_W-1:0] mem [MEM_WORDS];

    // Word index from the byte address
    assign idx = addr[WORD_LSB +: IDX_W];

    // Commands are only taken while idle, a write wins a malformed overlap
    assign accept_wr = (state == CTRL_IDLE) && !wr_n;
    assign accept_rd = (state == CTRL_IDLE) && !rd_n && wr_n;

    assign busy_n   = (state == CTRL_IDLE);
    assign rd_valid = (state == CTRL_READ) && (cnt == '0);
    assign rdata    = rdata_q;

    // Counter runs down from the delay minus one, done at zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= CTRL_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                CTRL_IDLE: begin
                    if (accept_wr) begin
                        state <= CTRL_WRITE;
                        cnt   <= CNT_W'(WRITE_CYCLES - 1);
                    end else if (accept_rd) begin
                        state <= CTRL_READ;
                        cnt   <= CNT_W'(CAS_LATENCY - 1);
                    end
                end
                CTRL_READ,
                CTRL_WRITE: begin
                    if (cnt == '0) begin
                        state <= CTRL_IDLE;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: begin
                    state <= CTRL_IDLE;
                    cnt   <= '0;
                end
            endcase
        end
    end

    // Storage array, cleared on reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int w = 0; w < MEM_WORDS; w++) begin
                mem[w] <= '0;
            end
        end else if (accept_wr) begin
            // Byte lanes with dqm low are written
            for (int b = 0; b < BE_W; b++) begin
                if (!dqm[b]) begin
                    mem[idx][b*BYTE_W +: BYTE_W] <= wdata[b*BYTE_W +: BYTE_W];
                end
            end
        end
    end

    // Word is fetched at acceptance and held through the CAS delay
    always_ff @(posedge clk) begin
        if (accept_rd) begin
            rdata_q <= mem[idx];
        end
    end

endmodule

/* verification/mem_subsystem_checker.sv */
module mem_subsystem_checker
    import mem_bus_pkg::*;
(
    input logic    clk,
    input logic    rst_n,
    input logic    i_gnt,
    input logic    i_rvalid,
    input mem_op_e i_op,
    input logic    i_pend,
    input logic    i_take,
    input logic    d_gnt,
    input logic    d_rvalid,
    input mem_op_e d_op,
    input logic    d_pend,
    input logic    d_take,
    input logic    rd_n,
    input logic    wr_n,
    input logic    busy_n
);

    // Failure count, read by the testbench at the end of the run
    int unsigned err_cnt = 0;

    strobe_excl: assert property (@(posedge clk) disable iff (!rst_n) !(!rd_n && !wr_n))
        else begin
            $error("rd_n and wr_n low together");
            err_cnt++;
        end

    take_excl: assert property (@(posedge clk) disable iff (!rst_n) !(i_take && d_take))
        else begin
            $error("both ports taken in one cycle");
            err_cnt++;
        end

    cmd_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
        !busy_n |-> (rd_n && wr_n))
        else begin
            $error("command issued while the controller is busy");
            err_cnt++;
        end

    quiet_in_reset: assert property (@(posedge clk)
        !rst_n |-> !(i_gnt || d_gnt || i_rvalid || d_rvalid))
        else begin
            $error("gnt or rvalid active during reset");
            err_cnt++;
        end

    // With the controller idle and the other side empty, a read takes 1 + CAS cycles
    i_read_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (i_gnt && i_op == MEM_READ && busy_n && !d_pend) |-> ##4 i_rvalid)
        else begin
            $error("instruction read did not return 4 cycles after gnt");
            err_cnt++;
        end

    d_read_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (d_gnt && d_op == MEM_READ && busy_n && !i_pend && !i_gnt) |-> ##4 d_rvalid)
        else begin
            $error("data read did not return 4 cycles after gnt");
            err_cnt++;
        end

endmodule

bind mem_subsystem_top mem_subsystem_checker protocol_chk (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_gnt    (i_gnt),
    .i_rvalid (i_rvalid),
    .i_op     (i_op),
    .i_pend   (i_pend),
    .i_take   (i_take),
    .d_gnt    (d_gnt),
    .d_rvalid (d_rvalid),
    .d_op     (d_op),
    .d_pend   (d_pend),
    .d_take   (d_take),
    .rd_n     (rd_n),
    .wr_n     (wr_n),
    .busy_n   (busy_n)
);

/* verification/mem_subsystem_tb.sv */
module mem_subsystem_tb
    import mem_bus_pkg::*;
    import sdram_pkg::*;
();

    localparam int RESET_CYCLES = 10;
    localparam int MIX_REQS     = 20;
    // Requests over all tests are 1 + 2 + 16 + 8 + 2 + 40
    localparam int TOTAL_REQS   = 69;
    localparam int CYCLE_LIMIT  = TOTAL_REQS * 12 + RESET_CYCLES;

    logic              clk;
    logic              rst_n;
    logic              i_req;
    logic [ADDR_W-1:0] i_addr;
    mem_op_e           i_op;
    logic [BE_W-1:0]   i_be;
    logic [DATA_W-1:0] i_wdata;
    logic              i_gnt;
    logic              i_rvalid;
    logic [DATA_W-1:0] i_rdata;
    logic              d_req;
    logic [ADDR_W-1:0] d_addr;
    mem_op_e           d_op;
    logic [BE_W-1:0]   d_be;
    logic [DATA_W-1:0] d_wdata;
    logic              d_gnt;
    logic              d_rvalid;
    logic [DATA_W-1:0] d_rdata;

    logic [DATA_W-1:0] ref_mem [MEM_WORDS];
    logic [31:0]       lfsr;
    logic [IDX_W-1:0]  widx [8];
    mem_op_e           mix_op [2][MIX_REQS];
    logic [IDX_W-1:0]  mix_idx [2][MIX_REQS];
    logic [BE_W-1:0]   mix_be [2][MIX_REQS];
    logic [DATA_W-1:0] mix_wd [2][MIX_REQS];
    int                cycles;
    int                errs;
    int                test_errs;
    int                pass_cnt;
    int                fail_cnt;
    int                i_rv_cnt;
    int                d_rv_cnt;

    mem_subsystem_top mem_subsystem_top_inst (.*);

    always #20 clk = ~clk;

    always @(negedge clk) begin
        if (i_rvalid) i_rv_cnt++;
        if (d_rvalid) d_rv_cnt++;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("tests failed");
            $finish;
        end
    end

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic drive(input bit side, input logic req, input mem_op_e op,
                         input logic [IDX_W-1:0] idx, input logic [BE_W-1:0] be,
                         input logic [DATA_W-1:0] wd);
        logic [ADDR_W-1:0] a;
        a = '0;
        a[WORD_LSB +: IDX_W] = idx;
        if (side) begin
            d_req   = req;
            d_op    = op;
            d_addr  = a;
            d_be    = be;
            d_wdata = wd;
        end else begin
            i_req   = req;
            i_op    = op;
            i_addr  = a;
            i_be    = be;
            i_wdata = wd;
        end
    endtask

    // One request on one side with lat counting cycles from gnt to rvalid
    task automatic do_req(input bit side, input mem_op_e op, input logic [IDX_W-1:0] idx,
                          input logic [BE_W-1:0] be, input logic [DATA_W-1:0] wd,
                          output int lat);
        logic [DATA_W-1:0] exp;
        logic [DATA_W-1:0] got;
        lat = 0;
        @(posedge clk);
        #2;
        drive(side, 1'b1, op, idx, be, wd);
        do begin
            @(negedge clk);
        end while (!(side ? d_gnt : i_gnt));
        exp = ref_mem[idx];
        if (op == MEM_WRITE) begin
            for (int b = 0; b < BE_W; b++) begin
                if (be[b]) ref_mem[idx][b*BYTE_W +: BYTE_W] = wd[b*BYTE_W +: BYTE_W];
            end
        end
        @(posedge clk);
        #2;
        drive(side, 1'b0, MEM_READ, '0, '0, '0);
        if (op == MEM_READ) begin
            do begin
                @(negedge clk);
                lat++;
            end while (!(side ? d_rvalid : i_rvalid));
            got = side ? d_rdata : i_rdata;
            assert (got == exp) else begin
                $display("FAIL %0t: %s read of word %0d expected %h, got %h",
                         $time, side ? "data" : "instr", idx, exp, got);
                errs++;
            end
        end
    endtask

    task automatic end_test(input string name);
        if (errs == test_errs) begin
            pass_cnt++;
            $display("test %s: passed", name);
        end else begin
            fail_cnt++;
            $display("test %s: failed with %0d errors", name, errs - test_errs);
        end
        test_errs = errs;
    endtask

    initial begin
        int lat_i;
        int lat_d;
        int chk_errs;
        int rv_i0;
        int rv_d0;
        logic [IDX_W-1:0] idx;
        logic [DATA_W-1:0] wd;
        clk = 1'b0;
        rst_n = 1'b0;
        lfsr = 32'h01050f36;
        {cycles, errs, test_errs, pass_cnt, fail_cnt, i_rv_cnt, d_rv_cnt} = '0;
        for (int w = 0; w < MEM_WORDS; w++) ref_mem[w] = '0;
        drive(1'b0, 1'b0, MEM_READ, '0, '0, '0);
        drive(1'b1, 1'b0, MEM_READ, '0, '0, '0);
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;

        @(negedge clk);
        assert (!i_gnt && !d_gnt && !i_rvalid && !d_rvalid) else begin
            $display("FAIL %0t: gnt or rvalid active right after reset", $time);
            errs++;
        end
        do_req(1'b1, MEM_READ, IDX_W'(rand_bits(IDX_W)), '0, '0, lat_d);
        end_test("reset state");

        idx = IDX_W'(rand_bits(IDX_W));
        wd  = rand_bits(DATA_W);
        do_req(1'b1, MEM_WRITE, idx, 4'hf, wd, lat_d);
        do_req(1'b1, MEM_READ, idx, '0, '0, lat_d);
        end_test("full word write");

        for (int k = 0; k < 8; k++) begin
            widx[k] = IDX_W'(rand_bits(IDX_W));
            do_req(1'b1, MEM_WRITE, widx[k], BE_W'(rand_bits(BE_W)), rand_bits(DATA_W), lat_d);
        end
        for (int k = 0; k < 8; k++) do_req(1'b1, MEM_READ, widx[k], '0, '0, lat_d);
        end_test("partial writes");

        for (int k = 0; k < 8; k++) begin
            do_req(1'b0, MEM_READ, widx[k], '0, '0, lat_i);
            assert (lat_i == 4) else begin
                $display("FAIL %0t: gnt to rvalid expected 4 cycles, got %0d", $time, lat_i);
                errs++;
            end
        end
        end_test("instruction reads");

        // Counters settle on the negedge, so baselines are taken on a posedge
        @(posedge clk);
        rv_i0 = i_rv_cnt;
        rv_d0 = d_rv_cnt;
        fork
            do_req(1'b0, MEM_READ, widx[0], '0, '0, lat_i);
            do_req(1'b1, MEM_READ, widx[1], '0, '0, lat_d);
        join
        @(posedge clk);
        assert (lat_i < lat_d && i_rv_cnt - rv_i0 == 1 && d_rv_cnt - rv_d0 == 1) else begin
            $display("FAIL %0t: contention order or rvalid count wrong, lat %0d/%0d",
                     $time, lat_i, lat_d);
            errs++;
        end
        end_test("simultaneous requests");

        // Each side works in its own half of the storage
        for (int s = 0; s < 2; s++) begin
            for (int k = 0; k < MIX_REQS; k++) begin
                mix_op[s][k]  = mem_op_e'(rand_bits(1));
                mix_idx[s][k] = IDX_W'(rand_bits(IDX_W - 1));
                mix_idx[s][k][IDX_W-1] = s[0];
                mix_be[s][k]  = BE_W'(rand_bits(BE_W));
                mix_wd[s][k]  = rand_bits(DATA_W);
            end
        end
        fork
            for (int k = 0; k < MIX_REQS; k++) begin
                do_req(1'b0, mix_op[0][k], mix_idx[0][k], mix_be[0][k], mix_wd[0][k], lat_i);
            end
            for (int k = 0; k < MIX_REQS; k++) begin
                do_req(1'b1, mix_op[1][k], mix_idx[1][k], mix_be[1][k], mix_wd[1][k], lat_d);
            end
        join
        end_test("random mix");

        repeat (2) @(posedge clk);
        chk_errs = mem_subsystem_top_inst.protocol_chk.err_cnt;
        if (chk_errs != 0) begin
            $display("Protocol checker saw %0d assertion failures", chk_errs);
        end
        $display("summary: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && chk_errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
